// File: sim.f
+incdir+testbench
hw/bpu_pkg.sv
hw/predecoder.sv
hw/ras.sv
hw/pred_cfg.sv
hw/bpu_top.sv
testbench/tb_bpu.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - files:
      - hw/bpu_pkg.sv
      - hw/predecoder.sv
      - hw/ras.sv
      - hw/pred_cfg.sv
      - hw/bpu_top.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_bpu.sv

// File: testbench/tb_vectors.svh
// row columns: word class, raw word (W_RAW only), execute feedback {call, ret, mis},
// config write strobe, config address (also the read address), config write data
task automatic build_table();
    // reset state, empty stack
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_OTHER, 32'h0,        FB_NONE, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_NONE,  32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    // direct jumps, random offsets of both signs
    add_row(W_B,     32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_BL,    32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_B,     32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_BL,    32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    // b back by 4 and bl forward by 16, fixed signs
    add_row(W_RAW,   32'h53FFF3FF, FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RAW,   32'h54004000, FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    // jirl forms that are not a plain return
    add_row(W_RAW,   32'h4C000021, FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RAW,   32'h4C000420, FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    // jump prediction off, then back on
    add_row(W_B,     32'h0,        FB_NONE, 1'b1, CFG_CTRL,   16'h0001);
    add_row(W_B,     32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_BL,    32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_BL,    32'h0,        FB_NONE, 1'b1, CFG_CTRL,   16'h0003);
    add_row(W_B,     32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    // fill the stack, drain it, one extra pop
    for (int i = 0; i < STACK_DEPTH; i++) begin
        add_row(W_NONE, 32'h0, FB_CALL, 1'b0, CFG_CTRL, 16'h0000);
    end
    for (int i = 0; i <= STACK_DEPTH; i++) begin
        add_row(W_RET, 32'h0, FB_NONE, 1'b0, CFG_CTRL, 16'h0000);
    end
    // call and return in the same cycle
    add_row(W_NONE,  32'h0,        FB_CALL, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_NONE,  32'h0,        FB_CALL, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RET,   32'h0,        FB_CALL, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    // recovery flag walk
    for (int i = 0; i < STACK_DEPTH; i++) begin
        add_row(W_NONE, 32'h0, FB_CALL, 1'b0, CFG_MISCNT, 16'h0000);
    end
    add_row(W_RET,   32'h0,        FB_RET_MIS, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_RET,   32'h0,        FB_RET_MIS, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_NONE,  32'h0,        FB_RET_MIS, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_NONE,  32'h0,        FB_RET_MIS, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE,    1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_NONE,  32'h0,        FB_RET_MIS, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_RET,   32'h0,        FB_RET_OK,  1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_NONE,  32'h0,        FB_RET_MIS, 1'b0, CFG_MISCNT, 16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE,    1'b0, CFG_MISCNT, 16'h0000);
    // counter clear, clear wins over a count
    add_row(W_OTHER, 32'h0,        FB_NONE,    1'b1, CFG_MISCNT, 16'h1234);
    add_row(W_OTHER, 32'h0,        FB_RET_MIS, 1'b1, CFG_MISCNT, 16'h0000);
    add_row(W_OTHER, 32'h0,        FB_NONE,    1'b0, CFG_MISCNT, 16'h0000);
    // return prediction off, stack must hold
    add_row(W_NONE,  32'h0,        FB_CALL, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_OTHER, 32'h0,        FB_NONE, 1'b1, CFG_CTRL,   16'h0002);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_OTHER, 32'h0,        FB_NONE, 1'b1, CFG_CTRL,   16'h0003);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
    add_row(W_RET,   32'h0,        FB_NONE, 1'b0, CFG_CTRL,   16'h0000);
endtask

// File: testbench/tb_bpu.sv
`timescale 1ns/100ps

module tb_bpu;
    import bpu_pkg::*;

    localparam int ADDR_WIDTH   = 29;
    localparam int STACK_DEPTH  = 16;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;

    // word classes
    localparam logic [2:0] W_NONE  = 3'd0;   // pdc_valid low
    localparam logic [2:0] W_OTHER = 3'd1;   // random non-branch
    localparam logic [2:0] W_B     = 3'd2;
    localparam logic [2:0] W_BL    = 3'd3;
    localparam logic [2:0] W_RET   = 3'd4;
    localparam logic [2:0] W_RAW   = 3'd5;

    // execute feedback {call, ret, mis}
    localparam logic [2:0] FB_NONE    = 3'b000;
    localparam logic [2:0] FB_CALL    = 3'b100;
    localparam logic [2:0] FB_RET_OK  = 3'b010;
    localparam logic [2:0] FB_RET_MIS = 3'b011;

    typedef struct packed {
        logic [2:0]  cls;
        logic [31:0] raw;
        logic [2:0]  fb;
        logic        wr;
        logic        addr;
        logic [15:0] wdata;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic                  pdc_valid;
    logic [ADDR_WIDTH-1:0] pdc_pc;
    instr_word_t           pdc_instr;
    logic                  pred_taken;
    logic [ADDR_WIDTH-1:0] pred_target;
    logic                  is_call_ex;
    logic [ADDR_WIDTH-1:0] ret_pc_ex;
    logic                  is_ret_ex;
    logic                  mis_pdc;
    logic                  cfg_wr;
    logic                  cfg_addr;
    logic [15:0]           cfg_wdata;
    logic [15:0]           cfg_rdata;

    row_t        rows[$];
    logic        table_ready;
    logic [31:0] rng_state;
    int          cur_row;

    // reference model
    logic [ADDR_WIDTH-1:0] model_stk [STACK_DEPTH];
    logic                  model_flag;
    logic                  model_ras_en;
    logic                  model_jmp_en;
    logic [CNT_W-1:0]      model_cnt;

    bpu_top #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .STACK_DEPTH (STACK_DEPTH)
    ) uut (
        .clk         (clk),
        .rstn        (rstn),
        .pdc_valid   (pdc_valid),
        .pdc_pc      (pdc_pc),
        .pdc_instr   (pdc_instr),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .is_call_ex  (is_call_ex),
        .ret_pc_ex   (ret_pc_ex),
        .is_ret_ex   (is_ret_ex),
        .mis_pdc     (mis_pdc),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // jirl r0, ra, 0
    function automatic logic word_is_return(input logic [31:0] w);
        return (w[31:26] == OP_JIRL) && (w[25:10] == 16'd0) &&
               (w[9:5] == RA_REG) && (w[4:0] == 5'd0);
    endfunction

    function automatic logic word_is_jump(input logic [31:0] w);
        return (w[31:26] == OP_B) || (w[31:26] == OP_BL);
    endfunction

    function automatic logic return_predicted();
        return pdc_valid && model_ras_en && word_is_return(pdc_instr);
    endfunction

    task automatic add_row(input logic [2:0] cls, input logic [31:0] raw,
                           input logic [2:0] fb, input logic wr, input logic addr,
                           input logic [15:0] wdata);
        row_t r;
        r.cls   = cls;
        r.raw   = raw;
        r.fb    = fb;
        r.wr    = wr;
        r.addr  = addr;
        r.wdata = wdata;
        rows.push_back(r);
    endtask

    `include "tb_vectors.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pred(input logic exp_taken, input logic [ADDR_WIDTH-1:0] exp_target);
        if (pred_taken !== exp_taken) begin
            abort_run($sformatf("mismatch pred_taken: got %h, expected %h at row %0d",
                                pred_taken, exp_taken, cur_row));
        end
        if (pred_target !== exp_target) begin
            abort_run($sformatf("mismatch pred_target: got %h, expected %h at row %0d",
                                pred_target, exp_target, cur_row));
        end
    endtask

    task automatic check_cfg(input logic [15:0] exp_rdata);
        if (cfg_rdata !== exp_rdata) begin
            abort_run($sformatf("mismatch cfg_rdata: got %h, expected %h at row %0d",
                                cfg_rdata, exp_rdata, cur_row));
        end
    endtask

    task automatic drive_row(input row_t r);
        logic [31:0] rnd;
        logic [31:0] word;
        rnd       = next_random();
        pdc_pc    = rnd[ADDR_WIDTH-1:0];
        rnd       = next_random();
        ret_pc_ex = rnd[ADDR_WIDTH-1:0];
        rnd       = next_random();
        case (r.cls)
            W_B:     word = {OP_B, rnd[15:0], rnd[25:16]};   // offs = rnd[25:0]
            W_BL:    word = {OP_BL, rnd[15:0], rnd[25:16]};
            W_RET:   word = {OP_JIRL, 16'h0000, RA_REG, 5'd0};
            W_RAW:   word = r.raw;
            default: begin
                word = rnd;
                if (word_is_jump(word) || (word[31:26] == OP_JIRL)) begin
                    word[31] = ~word[31];   // keep it a non-branch
                end
            end
        endcase
        pdc_valid = (r.cls != W_NONE);
        pdc_instr = word;
        {is_call_ex, is_ret_ex, mis_pdc} = r.fb;
        cfg_wr    = r.wr;
        cfg_addr  = r.addr;
        cfg_wdata = r.wdata;
    endtask

    task automatic check_outputs();
        logic [31:0]           word;
        logic [25:0]           offs;
        longint                sum;
        logic                  exp_taken;
        logic [ADDR_WIDTH-1:0] exp_target;
        logic [15:0]           exp_cfg;
        word       = pdc_instr;
        offs       = {word[9:0], word[25:10]};
        exp_taken  = 1'b0;
        exp_target = '0;
        if (return_predicted()) begin
            exp_taken  = 1'b1;
            exp_target = is_call_ex ? ret_pc_ex : model_stk[0];
        end else if (pdc_valid && model_jmp_en && word_is_jump(word)) begin
            sum        = longint'(pdc_pc) + longint'($signed(offs));
            exp_taken  = 1'b1;
            exp_target = sum[ADDR_WIDTH-1:0];   // modulo 2**ADDR_WIDTH
        end
        check_pred(exp_taken, exp_target);
        exp_cfg = 16'h0000;
        if (cfg_addr == CFG_MISCNT) begin
            exp_cfg = model_cnt;
        end else begin
            exp_cfg[CTRL_RAS_EN] = model_ras_en;
            exp_cfg[CTRL_JMP_EN] = model_jmp_en;
        end
        check_cfg(exp_cfg);
    endtask

    task automatic pop_model(input int n);
        for (int i = 0; i < STACK_DEPTH; i++) begin
            model_stk[i] = (i + n < STACK_DEPTH) ? model_stk[i + n] : '0;
        end
    endtask

    task automatic update_model();
        logic ret_hit;
        ret_hit = return_predicted();
        if (is_call_ex) begin
            if (!ret_hit) begin
                for (int i = STACK_DEPTH - 1; i > 0; i--) begin
                    model_stk[i] = model_stk[i-1];
                end
            end
            model_stk[0] = ret_pc_ex;
        end else if (is_ret_ex && mis_pdc) begin
            if (!model_flag) begin
                pop_model(ret_hit ? 3 : 2);
            end else begin
                pop_model(ret_hit ? 1 : 0);
            end
            model_flag = ~model_flag;
        end else if (is_ret_ex) begin
            model_flag = 1'b0;
            pop_model(ret_hit ? 1 : 0);
        end else if (ret_hit) begin
            pop_model(1);
        end
        if (cfg_wr && (cfg_addr == CFG_CTRL)) begin
            model_ras_en = cfg_wdata[CTRL_RAS_EN];
            model_jmp_en = cfg_wdata[CTRL_JMP_EN];
        end
        if (cfg_wr && (cfg_addr == CFG_MISCNT)) begin
            model_cnt = '0;
        end else if (is_ret_ex && mis_pdc && (model_cnt != '1)) begin
            model_cnt = model_cnt + 1'b1;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        pdc_valid    = 1'b0;
        pdc_pc       = '0;
        pdc_instr    = '0;
        is_call_ex   = 1'b0;
        ret_pc_ex    = '0;
        is_ret_ex    = 1'b0;
        mis_pdc      = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = CFG_CTRL;
        cfg_wdata    = '0;
        rng_state    = 32'h8f33;
        cur_row      = 0;
        table_ready  = 1'b0;
        for (int i = 0; i < STACK_DEPTH; i++) begin
            model_stk[i] = '0;
        end
        model_flag   = 1'b0;
        model_ras_en = 1'b1;
        model_jmp_en = 1'b1;
        model_cnt    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            cur_row = i;
            drive_row(rows[i]);
            #(CLK_PERIOD/2 - 10);   // just before the rising edge
            check_outputs();
            update_model();
            @(negedge clk);
        end
        $display("Done: no errors");
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready === 1'b1);
        #(CLK_PERIOD * (rows.size() + RESET_CYCLES + 50));
        abort_run("timeout: the test sequence did not complete in time");
    end

endmodule

// File: hw/bpu_top.sv
`timescale 1ns/100ps

module bpu_top #(
    parameter int ADDR_WIDTH  = 29,
    parameter int STACK_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rstn,
    // pre-decode stage
    input  logic                  pdc_valid,
    input  logic [ADDR_WIDTH-1:0] pdc_pc,
    input  bpu_pkg::instr_word_t  pdc_instr,
    output logic                  pred_taken,
    output logic [ADDR_WIDTH-1:0] pred_target,
    // execute feedback
    input  logic                  is_call_ex,
    input  logic [ADDR_WIDTH-1:0] ret_pc_ex,
    input  logic                  is_ret_ex,
    input  logic                  mis_pdc,
    // config port
    input  logic                  cfg_wr,
    input  logic                  cfg_addr,
    input  logic [15:0]           cfg_wdata,
    output logic [15:0]           cfg_rdata
);

    logic                  is_ret_pdc;
    logic [ADDR_WIDTH-1:0] ret_pc_pdc;
    logic                  ras_en;
    logic                  jmp_en;

    predecoder #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_predecoder (
        .pdc_valid   (pdc_valid),
        .pdc_pc      (pdc_pc),
        .pdc_instr   (pdc_instr),
        .ras_en      (ras_en),
        .jmp_en      (jmp_en),
        .ret_pc_pdc  (ret_pc_pdc),
        .is_ret_pdc  (is_ret_pdc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    ras #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .STACK_DEPTH (STACK_DEPTH)
    ) u_ras (
        .clk        (clk),
        .rstn       (rstn),
        .is_call_ex (is_call_ex),
        .ret_pc_ex  (ret_pc_ex),
        .is_ret_ex  (is_ret_ex),
        .mis_pdc    (mis_pdc),
        .is_ret_pdc (is_ret_pdc),
        .ret_pc_pdc (ret_pc_pdc)
    );

    pred_cfg u_pred_cfg (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .is_ret_ex (is_ret_ex),
        .mis_pdc   (mis_pdc),
        .ras_en    (ras_en),
        .jmp_en    (jmp_en)
    );

endmodule

// File: hw/pred_cfg.sv
`timescale 1ns/100ps

module pred_cfg (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cfg_wr,
    input  logic        cfg_addr,
    input  logic [15:0] cfg_wdata,
    output logic [15:0] cfg_rdata,
    input  logic        is_ret_ex,
    input  logic        mis_pdc,
    output logic        ras_en,
    output logic        jmp_en
);
    import bpu_pkg::*;

    logic [CNT_W-1:0] mis_cnt;
    logic             wr_ctrl;
    logic             wr_cnt;

    assign wr_ctrl = cfg_wr && (cfg_addr == CFG_CTRL);
    assign wr_cnt  = cfg_wr && (cfg_addr == CFG_MISCNT);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ras_en <= 1'b1;
            jmp_en <= 1'b1;
        end else if (wr_ctrl) begin
            ras_en <= cfg_wdata[CTRL_RAS_EN];
            jmp_en <= cfg_wdata[CTRL_JMP_EN];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mis_cnt <= '0;
        end else if (wr_cnt) begin
            mis_cnt <= '0;   // any write clears
        end else if (is_ret_ex && mis_pdc && (mis_cnt != '1)) begin
            mis_cnt <= mis_cnt + 1'b1;   // sticks at all ones
        end
    end

    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr == CFG_MISCNT) begin
            cfg_rdata = mis_cnt;
        end else begin
            cfg_rdata[CTRL_RAS_EN] = ras_en;
            cfg_rdata[CTRL_JMP_EN] = jmp_en;
        end
    end

endmodule

// File: hw/ras.sv
`timescale 1ns/100ps

module ras #(
    parameter int ADDR_WIDTH  = 29,
    parameter int STACK_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  is_call_ex,
    input  logic [ADDR_WIDTH-1:0] ret_pc_ex,
    input  logic                  is_ret_ex,
    input  logic                  mis_pdc,
    input  logic                  is_ret_pdc,
    output logic [ADDR_WIDTH-1:0] ret_pc_pdc
);

    logic [ADDR_WIDTH-1:0] stk [STACK_DEPTH];   // entry 0 is the top
    logic                  recov_flag;
    logic                  recov_flag_nxt;
    logic [1:0]            pop_n;

    // how far to pop this cycle, when no call is in the way
    always_comb begin
        pop_n          = 2'd0;
        recov_flag_nxt = recov_flag;
        if (is_call_ex) begin
            pop_n = 2'd0;   // handled as push or replace
        end else if (is_ret_ex && mis_pdc) begin
            recov_flag_nxt = ~recov_flag;
            if (!recov_flag) begin
                pop_n = is_ret_pdc ? 2'd3 : 2'd2;
            end else begin
                pop_n = is_ret_pdc ? 2'd1 : 2'd0;
            end
        end else if (is_ret_ex) begin
            recov_flag_nxt = 1'b0;   // good return, start over
            pop_n          = is_ret_pdc ? 2'd1 : 2'd0;
        end else if (is_ret_pdc) begin
            pop_n = 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            recov_flag <= 1'b0;
        end else begin
            recov_flag <= recov_flag_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < STACK_DEPTH; i++) begin
                stk[i] <= '0;
            end
        end else if (is_call_ex) begin
            stk[0] <= ret_pc_ex;
            if (!is_ret_pdc) begin
                // push, bottom entry falls off
                for (int i = 1; i < STACK_DEPTH; i++) begin
                    stk[i] <= stk[i-1];
                end
            end
        end else begin
            for (int i = 0; i < STACK_DEPTH; i++) begin
                if (i + int'(pop_n) < STACK_DEPTH) begin
                    stk[i] <= stk[i + int'(pop_n)];
                end else begin
                    stk[i] <= '0;   // zero fill from below
                end
            end
        end
    end

    always_comb begin
        ret_pc_pdc = '0;
        if (is_ret_pdc) begin
            if (is_call_ex) begin
                ret_pc_pdc = ret_pc_ex;   // call still in flight
            end else begin
                ret_pc_pdc = stk[0];
            end
        end
    end

endmodule

// File: hw/predecoder.sv
`timescale 1ns/100ps

module predecoder #(
    parameter int ADDR_WIDTH = 29
) (
    input  logic                  pdc_valid,
    input  logic [ADDR_WIDTH-1:0] pdc_pc,
    input  bpu_pkg::instr_word_t  pdc_instr,
    input  logic                  ras_en,
    input  logic                  jmp_en,
    input  logic [ADDR_WIDTH-1:0] ret_pc_pdc,
    output logic                  is_ret_pdc,
    output logic                  pred_taken,
    output logic [ADDR_WIDTH-1:0] pred_target
);
    import bpu_pkg::*;

    logic [25:0]           offs26;
    logic [ADDR_WIDTH-1:0] offs_sext;
    logic [ADDR_WIDTH-1:0] jmp_target;
    logic                  is_jmp_word;
    logic                  is_ret_word;
    logic                  jmp_hit;

    // jump format view
    assign offs26    = {pdc_instr.jfmt.offs_hi, pdc_instr.jfmt.offs_lo};
    assign offs_sext = {{(ADDR_WIDTH-26){offs26[25]}}, offs26};

    assign is_jmp_word = (pdc_instr.jfmt.opcode == OP_B) ||
                         (pdc_instr.jfmt.opcode == OP_BL);

    assign jmp_target = pdc_pc + offs_sext;   // wraps at ADDR_WIDTH

    // register format view, jirl r0, ra, 0
    assign is_ret_word = (pdc_instr.rfmt.opcode == OP_JIRL) &&
                         (pdc_instr.rfmt.rd == 5'd0) &&
                         (pdc_instr.rfmt.rj == RA_REG) &&
                         (pdc_instr.rfmt.offs16 == 16'd0);

    assign jmp_hit    = pdc_valid && jmp_en && is_jmp_word;
    assign is_ret_pdc = pdc_valid && ras_en && is_ret_word;

    assign pred_taken = jmp_hit || is_ret_pdc;

    always_comb begin
        pred_target = '0;
        if (is_ret_pdc) begin
            pred_target = ret_pc_pdc;   // from RAS top or forwarded call
        end else if (jmp_hit) begin
            pred_target = jmp_target;
        end
    end

endmodule

// File: hw/bpu_pkg.sv
package bpu_pkg;

    // one fetched word, seen as either of the two branch encodings
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;   // offs[15:0]
            logic [9:0]  offs_hi;   // offs[25:16]
        } jfmt;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } rfmt;
    } instr_word_t;

    // major opcodes, bits 31:26
    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;  // call

    localparam logic [4:0] RA_REG = 5'd1;   // return address register

    // config register map
    localparam logic CFG_CTRL   = 1'b0;
    localparam logic CFG_MISCNT = 1'b1;

    // control register bits
    localparam int CTRL_RAS_EN = 0;
    localparam int CTRL_JMP_EN = 1;

    localparam int CNT_W = 16;   // return mispredict counter

endpackage
